/* raster_consts.svh */
// Fixed-point format and primitive sizes for the raster iterator
// Width and radix of coordinates and colors, vertex/axis/color counts
// and the shift that turns a multisample code into a step size
`ifndef RASTER_CONSTS_SVH
`define RASTER_CONSTS_SVH

// Total bits in every coordinate and color channel
`define SIGFIG 24

// Fraction bits, integer part sits above these
`define RADIX 10

// Vertices per triangle
`define VERTS 3

// Axes per vertex, (x, y, z)
`define AXIS 3

// Color channels
`define COLORS 3

// One-hot code shifted left by this lands on the sample pitch
// 1000 -> one pixel, 0001 -> an eighth of a pixel
`define SS_SHIFT (`RADIX - 3)

`endif

/* iter_pkg.sv */
// Control types for the sample iterator
// FSM state encoding and the one-hot multisample code

package iter_pkg;

    // Waiting for a triangle, or walking its box
    typedef enum logic {
        ST_WAIT = 1'b0,
        ST_TEST = 1'b1
    } iter_state_t;

    // One-hot multisample code
    // 1000 1x, 0100 4x, 0010 16x, 0001 64x
    typedef logic [3:0] ss_code_t;

endpackage

/* geom_pkg.sv */
// Geometry types shared by the iterator datapath
// Scalar coordinate and color words, points, vertices,
// triangles, color triples and bounding boxes
`include "raster_consts.svh"

package geom_pkg;

    // Signed fixed point, RADIX fraction bits
    typedef logic signed [`SIGFIG-1:0] coord_t;

    // Unsigned color channel
    typedef logic [`SIGFIG-1:0] color_t;

    // Sample location on the screen plane
    typedef struct packed {
        coord_t x;
        coord_t y;
    } point_t;

    // Index 0 is x, 1 is y, 2 is z
    typedef coord_t [`AXIS-1:0] vert_t;

    typedef vert_t [`VERTS-1:0] tri_t;

    typedef color_t [`COLORS-1:0] rgb_t;

    // Lower left corner first, then upper right
    typedef struct packed {
        point_t ll;
        point_t ur;
    } box_t;

endpackage

/* iter_ctrl.sv */
// Iterator control FSM
// Two states, wait and test, with registered valid and halt outputs
// and combinational capture/advance strobes for the datapath
`include "raster_consts.svh"

module iter_ctrl (
    input  logic clk,
    input  logic rst,
    input  logic valid_tri,
    input  logic at_end,
    output logic capture,
    output logic advance,
    output logic valid_samp,
    output logic halt_l
);
    import iter_pkg::*;

    iter_state_t state;
    iter_state_t next_state;

    // Next state
    always_comb begin
        next_state = state;
        case (state)
            ST_WAIT: begin
                // Accept whatever is presented with valid_tri
                if (valid_tri) begin
                    next_state = ST_TEST;
                end
            end
            ST_TEST: begin
                // Last sample of the box goes out this cycle
                if (at_end) begin
                    next_state = ST_WAIT;
                end
            end
            default: begin
                next_state = ST_WAIT;
            end
        endcase
    end

    // Strobes to the datapath
    // Capture tracks the inputs the whole time we wait
    assign capture = (state == ST_WAIT);
    assign advance = (state == ST_TEST) && !at_end;

    // State plus Moore outputs, all updated on the same edge
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            state      <= ST_WAIT;
            valid_samp <= 1'b0;
            halt_l     <= 1'b1;
        end else begin
            state      <= next_state;
            // Valid and halt mirror the state being entered
            valid_samp <= (next_state == ST_TEST);
            halt_l     <= (next_state != ST_TEST);
        end
    end

endmodule

/* sample_stepper.sv */
// Bounding box walker
// Holds the current box and sample, steps raster order left to right
// then bottom to top, and flags the right edge and the end of the box
`include "raster_consts.svh"

module sample_stepper (
    input  logic               clk,
    input  logic               rst,
    input  logic               capture,
    input  logic               advance,
    input  geom_pkg::box_t     box_in,
    input  iter_pkg::ss_code_t ss_code,
    output geom_pkg::point_t   sample,
    output logic               at_right,
    output logic               at_end
);
    import geom_pkg::*;

    // Box being walked, loaded on capture
    box_t box;

    // Distance between neighboring samples in fixed point
    coord_t step;

    // Top row reached
    logic at_top;

    // One-hot code zero extended, then moved into the fraction bits
    assign step = coord_t'(ss_code) << `SS_SHIFT;

    // Edges are reached at or beyond the max, since the max
    // need not sit on the sample grid
    assign at_right = (sample.x >= box.ur.x);
    assign at_top   = (sample.y >= box.ur.y);
    assign at_end   = at_right && at_top;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            box    <= '0;
            sample <= '0;
        end else if (capture) begin
            // Follow the input box so the first sample is ready on accept
            box    <= box_in;
            sample <= box_in.ll;
        end else if (advance) begin
            if (at_right) begin
                // Wrap to the left edge, one row up
                sample.x <= box.ll.x;
                sample.y <= sample.y + step;
            end else begin
                // Same row, next column
                sample.x <= sample.x + step;
            end
        end else begin
            // Done with the box, park on its lower left
            sample <= box.ll;
        end
    end

endmodule

/* prim_hold.sv */
// Triangle and color holding registers
// Loaded when the controller captures, then held steady
// for every sample of that triangle
`include "raster_consts.svh"

module prim_hold (
    input  logic            clk,
    input  logic            rst,
    input  logic            capture,
    input  geom_pkg::tri_t  tri_in,
    input  geom_pkg::rgb_t  color_in,
    output geom_pkg::tri_t  tri_out,
    output geom_pkg::rgb_t  color_out
);

    // Capture is high through the whole wait state, so the
    // registers follow the input until the triangle is accepted
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            tri_out   <= '0;
            color_out <= '0;
        end else if (capture) begin
            tri_out   <= tri_in;
            color_out <= color_in;
        end
    end

endmodule

/* test_iterator.sv */
// Sample test iterator top level
// Controller FSM, box walker and primitive holding registers
// Upstream is stalled through halt_l while a box is walked
`include "raster_consts.svh"

module test_iterator (
    input  logic               clk,
    input  logic               rst,
    input  geom_pkg::tri_t     tri_in,
    input  geom_pkg::rgb_t     color_in,
    input  geom_pkg::box_t     box_in,
    input  logic               valid_tri,
    input  iter_pkg::ss_code_t ss_code,
    output geom_pkg::tri_t     tri_out,
    output geom_pkg::rgb_t     color_out,
    output geom_pkg::point_t   sample,
    output logic               valid_samp,
    output logic               halt_l
);

    // Controller strobes
    logic capture;
    logic advance;

    // Last sample of the box
    logic at_end;

    iter_ctrl u_ctrl (
        .clk        (clk),
        .rst        (rst),
        .valid_tri  (valid_tri),
        .at_end     (at_end),
        .capture    (capture),
        .advance    (advance),
        .valid_samp (valid_samp),
        .halt_l     (halt_l)
    );

    // Right edge flag is used only inside the walker
    sample_stepper u_step (
        .clk      (clk),
        .rst      (rst),
        .capture  (capture),
        .advance  (advance),
        .box_in   (box_in),
        .ss_code  (ss_code),
        .sample   (sample),
        .at_right (),
        .at_end   (at_end)
    );

    prim_hold u_hold (
        .clk       (clk),
        .rst       (rst),
        .capture   (capture),
        .tri_in    (tri_in),
        .color_in  (color_in),
        .tri_out   (tri_out),
        .color_out (color_out)
    );

endmodule

/* test_iterator_chk.sv */
// Concurrent checks for the iterator
// Sample stays within the held box grown by one step while advancing,
// FSM accepts on valid_tri and returns to wait at the end of the box

module test_iterator_chk (
    input logic                clk,
    input logic                rst,
    input logic                advance,
    input geom_pkg::point_t    sample,
    input geom_pkg::box_t      box,
    input geom_pkg::coord_t    step,
    input iter_pkg::iter_state_t state,
    input logic                valid_tri,
    input logic                at_end
);
    timeunit 1ns;
    timeprecision 1ps;
    import iter_pkg::*;

    // Last column and row may overshoot the max by less than one step
    a_in_box: assert property (@(posedge clk) disable iff (rst)
        advance |-> (sample.x >= box.ll.x && sample.y >= box.ll.y &&
                     sample.x < box.ur.x + step && sample.y < box.ur.y + step))
        else $error("sample left the held box while advancing");

    a_accept: assert property (@(posedge clk) disable iff (rst)
        (state == ST_WAIT && valid_tri) |=> (state == ST_TEST))
        else $error("triangle offered in wait state was not accepted");

    a_finish: assert property (@(posedge clk) disable iff (rst)
        (state == ST_TEST && at_end) |=> (state == ST_WAIT))
        else $error("iterator did not return to wait after the last sample");

endmodule

// Datapath copy, FSM inputs tied so the state checks stay idle
bind sample_stepper test_iterator_chk u_chk_step (
    .clk       (clk),
    .rst       (rst),
    .advance   (advance),
    .sample    (sample),
    .box       (box),
    .step      (step),
    .state     (iter_pkg::ST_WAIT),
    .valid_tri (1'b0),
    .at_end    (at_end)
);

// Controller copy, advance tied low so the box check stays idle
bind iter_ctrl test_iterator_chk u_chk_ctrl (
    .clk       (clk),
    .rst       (rst),
    .advance   (1'b0),
    .sample    ('0),
    .box       ('0),
    .step      ('0),
    .state     (state),
    .valid_tri (valid_tri),
    .at_end    (at_end)
);

/* tb_test_iterator.sv */
// Testbench for the sample test iterator
// Clock and reset, random triangles and boxes from an xorshift generator,
// reference sample list and a comparing process on the falling edge
`include "raster_consts.svh"

module tb_test_iterator;
    timeunit 1ns;
    timeprecision 1ps;
    import geom_pkg::*;
    import iter_pkg::*;

    localparam int NUM_TRI = 12;
    // One pixel in fixed point
    localparam int PIX = 1 << `RADIX;

    typedef point_t point_q_t[$];

    logic     clk;
    logic     rst;
    tri_t     tri_in;
    rgb_t     color_in;
    box_t     box_in;
    logic     valid_tri;
    ss_code_t ss_code;
    tri_t     tri_out;
    rgb_t     color_out;
    point_t   sample;
    logic     valid_samp;
    logic     halt_l;

    // Pre-generated stimulus, one entry per triangle
    box_t     boxes[NUM_TRI];
    tri_t     tris[NUM_TRI];
    rgb_t     cols[NUM_TRI];
    ss_code_t codes[NUM_TRI];
    int       gaps[NUM_TRI];

    // Expected samples, with a flag on the last one of each triangle
    point_t   exp_q[$];
    bit       last_q[$];
    tri_t     exp_tri;
    rgb_t     exp_col;

    logic [31:0] rng_state = 32'd66427;
    int   error_count = 0;
    int   cycle_count = 0;
    int   cycle_limit = 0;
    logic prev_last = 1'b0;
    logic in_tri = 1'b0;

    test_iterator u_dut (
        .clk        (clk),
        .rst        (rst),
        .tri_in     (tri_in),
        .color_in   (color_in),
        .box_in     (box_in),
        .valid_tri  (valid_tri),
        .ss_code    (ss_code),
        .tri_out    (tri_out),
        .color_out  (color_out),
        .sample     (sample),
        .valid_samp (valid_samp),
        .halt_l     (halt_l)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    task automatic report_error(input string msg);
        error_count++;
        $display("%s", msg);
        $display("Finished with errors");
        $fatal(1, "stopping at first error");
    endtask

    // 32-bit xorshift
    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic int rand_below(input int n);
        return int'(next_rand() % 32'(n));
    endfunction

    // Raster order walk of one box: columns until the first x at or
    // above x max, rows the same way in y, bottom row first
    function automatic point_q_t ref_samples(input box_t b, input ss_code_t c);
        point_q_t q;
        point_t   p;
        int       x;
        int       y;
        int       step;
        logic     col_done;
        logic     row_done;
        step = int'(c) << `SS_SHIFT;
        y = int'(b.ll.y);
        row_done = 1'b0;
        while (!row_done) begin
            x = int'(b.ll.x);
            col_done = 1'b0;
            while (!col_done) begin
                p.x = coord_t'(x);
                p.y = coord_t'(y);
                q.push_back(p);
                if (x >= int'(b.ur.x)) col_done = 1'b1;
                else x = x + step;
            end
            if (y >= int'(b.ur.y)) row_done = 1'b1;
            else y = y + step;
        end
        return q;
    endfunction

    // Boxes span 0 to 3 pixels, first one has zero span
    // Each code differs from the one before it
    task automatic gen_stimulus();
        int       i;
        int       v;
        int       x0;
        int       y0;
        int       span_x;
        int       span_y;
        int       code_idx;
        point_q_t pts;
        code_idx = 0;
        for (i = 0; i < NUM_TRI; i++) begin
            x0 = rand_below(1 << 17) - (1 << 16);
            y0 = rand_below(1 << 17) - (1 << 16);
            span_x = (i == 0) ? 0 : rand_below(3 * PIX + 1);
            span_y = (i == 0) ? 0 : rand_below(3 * PIX + 1);
            boxes[i].ll.x = coord_t'(x0);
            boxes[i].ll.y = coord_t'(y0);
            boxes[i].ur.x = coord_t'(x0 + span_x);
            boxes[i].ur.y = coord_t'(y0 + span_y);
            code_idx = (code_idx + 1 + rand_below(3)) % 4;
            codes[i] = 4'b1000 >> code_idx;
            // Every third triangle follows its predecessor with no gap
            gaps[i] = (i % 3 == 1) ? 0 : rand_below(3);
            for (v = 0; v < `VERTS * `AXIS; v++) begin
                tris[i][v / `AXIS][v % `AXIS] = coord_t'(next_rand());
            end
            for (v = 0; v < `COLORS; v++) begin
                cols[i][v] = color_t'(next_rand());
            end
            // Samples plus wait and gap cycles
            pts = ref_samples(boxes[i], codes[i]);
            cycle_limit += pts.size() + 10;
        end
        // Reset and idle cycles around the triangles
        cycle_limit += 50;
    endtask

    // Timeout
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        assert (cycle_count <= cycle_limit)
            else report_error($sformatf("timeout after %0d cycles", cycle_count));
    end

    // Stimulus, driven 1 ns after the rising edge
    initial begin
        int       i;
        int       k;
        point_q_t pts;
        rst = 1'b1;
        valid_tri = 1'b0;
        tri_in = '0;
        color_in = '0;
        box_in = '0;
        ss_code = 4'b1000;
        gen_stimulus();
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        // Quiet outputs before any triangle, starting from the reset values
        repeat (3) begin
            assert (valid_samp == 1'b0)
                else report_error($sformatf("mismatch valid_samp exp=%h got=%h",
                                            1'b0, valid_samp));
            assert (halt_l == 1'b1)
                else report_error($sformatf("mismatch halt_l exp=%h got=%h", 1'b1, halt_l));
            @(posedge clk);
            #1;
        end
        for (i = 0; i < NUM_TRI; i++) begin
            // Zero gap gives back to back triangles
            for (k = 0; k < gaps[i]; k++) begin
                valid_tri = 1'b0;
                @(posedge clk);
                #1;
            end
            pts = ref_samples(boxes[i], codes[i]);
            for (k = 0; k < pts.size(); k++) begin
                exp_q.push_back(pts[k]);
                last_q.push_back(k == pts.size() - 1);
            end
            exp_tri = tris[i];
            exp_col = cols[i];
            tri_in = tris[i];
            color_in = cols[i];
            box_in = boxes[i];
            ss_code = codes[i];
            valid_tri = 1'b1;
            @(posedge clk);
            #1;
            assert (halt_l == 1'b0)
                else report_error("triangle was not accepted while the iterator waited");
            // Hold everything until the walk ends
            while (halt_l == 1'b0) begin
                @(posedge clk);
                #1;
            end
        end
        valid_tri = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        assert (exp_q.size() == 0)
            else report_error("some expected samples were never produced");
        if (error_count == 0) begin
            $display("Finished with no errors");
            $finish;
        end else begin
            report_error("errors were found during the run");
        end
    end

    // Compare on the falling edge, away from the driving edge
    always @(negedge clk) begin : compare
        point_t exp_p;
        logic   exp_last;
        if (!rst) begin
            assert (halt_l == !valid_samp)
                else report_error($sformatf("mismatch halt_l exp=%h got=%h",
                                            !valid_samp, halt_l));
            if (prev_last) begin
                assert (!valid_samp)
                    else report_error("valid_samp stayed high after the last sample");
            end
            assert (!(in_tri && !valid_samp))
                else report_error("valid_samp fell before the last sample of a triangle");
            if (valid_samp) begin
                assert (exp_q.size() > 0)
                    else report_error("valid sample arrived with none expected");
                exp_p = exp_q.pop_front();
                exp_last = last_q.pop_front();
                assert (sample.x == exp_p.x)
                    else report_error($sformatf("mismatch sample.x exp=%h got=%h",
                                                exp_p.x, sample.x));
                assert (sample.y == exp_p.y)
                    else report_error($sformatf("mismatch sample.y exp=%h got=%h",
                                                exp_p.y, sample.y));
                assert (tri_out == exp_tri)
                    else report_error($sformatf("mismatch tri_out exp=%h got=%h",
                                                exp_tri, tri_out));
                assert (color_out == exp_col)
                    else report_error($sformatf("mismatch color_out exp=%h got=%h",
                                                exp_col, color_out));
                prev_last = exp_last;
                in_tri = !exp_last;
            end else begin
                prev_last = 1'b0;
                in_tri = 1'b0;
            end
        end
    end

endmodule

/* list.f */
+incdir+.
iter_pkg.sv
geom_pkg.sv
iter_ctrl.sv
sample_stepper.sv
prim_hold.sv
test_iterator.sv
test_iterator_chk.sv
tb_test_iterator.sv

/* run.sh */
#!/bin/sh
# Build and run the testbench with Verilator, pass is decided from the log
rm -rf obj_dir sim.log
verilator --binary --assert --timescale 1ns/1ps -f list.f --top-module tb_test_iterator \
    && ./obj_dir/Vtb_test_iterator 2>&1 | tee sim.log
grep -q "^Finished with no errors$" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
